// ==== hdl/eva_pkg.sv ====
// eva_pkg: address widths, field layouts, overflow range and the eva_u union
package eva_pkg;

  // address and coordinate widths
  localparam int eva_width_lp    = 32;   // byte address from the core
  localparam int epa_width_lp    = 28;   // endpoint word address
  localparam int x_cord_width_lp = 7;
  localparam int y_cord_width_lp = 6;
  localparam int pod_x_width_lp  = 3;
  localparam int pod_y_width_lp  = 3;
  localparam int x_sub_width_lp  = 4;    // 16 tiles across
  localparam int y_sub_width_lp  = 3;    // 8 tiles down

  // field layouts
  localparam int vcache_block_words_lp   = 8;
  localparam int global_epa_width_lp     = 15;
  localparam int tile_group_epa_width_lp = 14;

  // dmem region, word addresses in tile-group space
  localparam logic [tile_group_epa_width_lp-1:0] dmem_epa_mask_lp = 14'h03FF;
  localparam logic [tile_group_epa_width_lp-1:0] overflow_lo_lp   = 14'h0100;
  localparam logic [tile_group_epa_width_lp-1:0] overflow_hi_lp   = 14'h04FF;

  // config word: {pod_y, pod_x, tgo_y, tgo_x}, low to high
  localparam int cfg_width_lp = 13;

  // dram striping, derived from the layout above
  localparam int block_offset_width_lp = $clog2(vcache_block_words_lp);
  localparam int dram_word_width_lp    = eva_width_lp - 3;  // drop bit 31 and byte offset
  // word bits left above offset, column and north/south select
  localparam int dram_upper_width_lp   =
      dram_word_width_lp - block_offset_width_lp - x_sub_width_lp - 1;

  // global view: 01 at the top, coordinates are absolute
  typedef struct packed {
    logic [1:0]                     remote;
    logic [y_cord_width_lp-1:0]     y_cord;
    logic [x_cord_width_lp-1:0]     x_cord;
    logic [global_epa_width_lp-1:0] addr;     // word address
    logic [1:0]                     byte_ofs;
  } global_addr_t;

  // tile-group view: 001 at the top, coordinates relative to the origin
  typedef struct packed {
    logic [2:0]                         remote;
    logic [y_cord_width_lp-1:0]         y_cord;
    logic [x_cord_width_lp-1:0]         x_cord;
    logic [tile_group_epa_width_lp-1:0] addr;
    logic [1:0]                         byte_ofs;
  } tile_group_addr_t;

  // one eva, two decodings
  typedef union packed {
    global_addr_t     global_v;
    tile_group_addr_t tile_group_v;
  } eva_u;

endpackage

// ==== hdl/npa_if.sv ====
// npa_if: one network physical address (x, y, epa, invalid) with source and sink modports
`timescale 1ns/1ps

interface npa_if;
  import eva_pkg::*;

  logic [x_cord_width_lp-1:0] x_cord;   // global x
  logic [y_cord_width_lp-1:0] y_cord;   // global y
  logic [epa_width_lp-1:0]    epa;      // word address at the endpoint
  logic                       invalid;  // eva maps to nothing remote

  // producer side, hash or translator
  modport source (
    output x_cord,
    output y_cord,
    output epa,
    output invalid
  );

  // consumer side
  modport sink (
    input x_cord,
    input y_cord,
    input epa,
    input invalid
  );

endinterface

// ==== hdl/dram_hash.sv ====
// dram_hash: stripes a dram eva across the north and south vcache rows by cache block
`timescale 1ns/1ps

module dram_hash (
  input  eva_pkg::eva_u                      eva_i,
  input  logic [eva_pkg::pod_x_width_lp-1:0] pod_x_i,
  input  logic [eva_pkg::pod_y_width_lp-1:0] pod_y_i,
  npa_if.source                              npa
);
  import eva_pkg::*;

  logic [dram_word_width_lp-1:0]    word_addr;   // eva[30:2]
  logic [block_offset_width_lp-1:0] block_ofs;   // word inside the block
  logic [x_sub_width_lp-1:0]        vcache_col;  // which vcache in the row
  logic                             is_south;    // 0 north, 1 south
  logic [dram_upper_width_lp-1:0]   upper_addr;  // block index inside one vcache
  logic [pod_y_width_lp-1:0]        row_pod_y;
  logic [y_sub_width_lp-1:0]        row_sub_y;

  // bit 31 only tags the space, drop it with the byte offset
  assign word_addr = eva_i[eva_width_lp-2:2];

  // word address fields, low to high: offset, column, row, rest
  assign block_ofs  = word_addr[block_offset_width_lp-1:0];
  assign vcache_col = word_addr[block_offset_width_lp +: x_sub_width_lp];
  assign is_south   = word_addr[block_offset_width_lp + x_sub_width_lp];
  assign upper_addr = word_addr[dram_word_width_lp-1 -: dram_upper_width_lp];

  // vcache rows sit one pod above and one pod below
  always_comb begin
    if (is_south) begin
      row_pod_y = pod_y_i + 1'b1;
      row_sub_y = '0;  // first tile row of the pod below
    end else begin
      row_pod_y = pod_y_i - 1'b1;
      row_sub_y = '1;  // last tile row of the pod above
    end
  end

  // columns line up with the tile columns of this pod
  assign npa.x_cord = {pod_x_i, vcache_col};
  assign npa.y_cord = {row_pod_y, row_sub_y};

  // block index and offset packed back together, zero extended
  assign npa.epa = {
    {(epa_width_lp-dram_upper_width_lp-block_offset_width_lp){1'b0}},
    upper_addr,
    block_ofs
  };

  // every dram address lands somewhere
  assign npa.invalid = 1'b0;

endmodule

// ==== hdl/eva_to_npa.sv ====
// eva_to_npa: classifies an eva and picks the dram, global, tile-group or overflow mapping
`timescale 1ns/1ps

module eva_to_npa (
  input  eva_pkg::eva_u                      eva_i,
  input  logic [eva_pkg::x_sub_width_lp-1:0] tgo_x_i,  // tile-group origin x
  input  logic [eva_pkg::y_sub_width_lp-1:0] tgo_y_i,  // tile-group origin y
  input  logic [eva_pkg::pod_x_width_lp-1:0] pod_x_i,
  input  logic [eva_pkg::pod_y_width_lp-1:0] pod_y_i,
  npa_if.source                              npa
);
  import eva_pkg::*;

  eva_u                               ovf_eva;      // same eva, bit 31 forced on
  logic                               is_dram;
  logic                               is_global;
  logic                               is_tile_group;
  logic                               in_overflow;
  logic [tile_group_epa_width_lp-1:0] tg_addr;
  logic [x_sub_width_lp-1:0]          tg_x_sub;    // wraps mod 16
  logic [y_sub_width_lp-1:0]          tg_y_sub;    // wraps mod 8

  npa_if dram_npa ();  // plain dram hash result
  npa_if ovf_npa ();   // overflowed dmem hash result

  // address kind from the top bits
  assign is_dram       = eva_i[eva_width_lp-1];
  assign is_global     = eva_i.global_v.remote == 2'b01;
  assign is_tile_group = eva_i.tile_group_v.remote == 3'b001;

  // dmem words past the local range spill into dram
  assign tg_addr     = eva_i.tile_group_v.addr;
  assign in_overflow = (tg_addr >= overflow_lo_lp) && (tg_addr <= overflow_hi_lp);
  assign ovf_eva     = {1'b1, eva_i[eva_width_lp-2:0]};

  // relative coordinates, origin added inside the pod
  assign tg_x_sub = eva_i.tile_group_v.x_cord[x_sub_width_lp-1:0] + tgo_x_i;
  assign tg_y_sub = eva_i.tile_group_v.y_cord[y_sub_width_lp-1:0] + tgo_y_i;

  dram_hash dram_hash_u (
    .eva_i   (eva_i),
    .pod_x_i (pod_x_i),
    .pod_y_i (pod_y_i),
    .npa     (dram_npa)
  );

  dram_hash overflow_hash_u (
    .eva_i   (ovf_eva),
    .pod_x_i (pod_x_i),
    .pod_y_i (pod_y_i),
    .npa     (ovf_npa)
  );

  // priority: dram, global, overflow, tile-group, else invalid
  always_comb begin
    npa.x_cord  = '0;
    npa.y_cord  = '0;
    npa.epa     = '0;
    npa.invalid = 1'b0;
    if (is_dram) begin
      npa.x_cord = dram_npa.x_cord;
      npa.y_cord = dram_npa.y_cord;
      npa.epa    = dram_npa.epa;
    end else if (is_global) begin
      // coordinates and word address sit in the eva as is
      npa.x_cord = eva_i.global_v.x_cord;
      npa.y_cord = eva_i.global_v.y_cord;
      npa.epa    = {{(epa_width_lp-global_epa_width_lp){1'b0}}, eva_i.global_v.addr};
    end else if (is_tile_group && in_overflow) begin
      npa.x_cord = ovf_npa.x_cord;
      npa.y_cord = ovf_npa.y_cord;
      npa.epa    = ovf_npa.epa;
    end else if (is_tile_group) begin
      npa.x_cord = {pod_x_i, tg_x_sub};
      npa.y_cord = {pod_y_i, tg_y_sub};
      // keep it inside the physical dmem
      npa.epa    = {{(epa_width_lp-tile_group_epa_width_lp){1'b0}}, tg_addr & dmem_epa_mask_lp};
    end else begin
      npa.invalid = 1'b1;  // outputs stay at zero
    end
  end

endmodule

// ==== hdl/xlate_cfg.sv ====
// xlate_cfg: tile-group origin and pod coordinate registers loaded from one config word
`timescale 1ns/1ps

module xlate_cfg (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               cfg_we_i,
  input  logic [eva_pkg::cfg_width_lp-1:0]   cfg_data_i,
  output logic [eva_pkg::x_sub_width_lp-1:0] tgo_x_o,
  output logic [eva_pkg::y_sub_width_lp-1:0] tgo_y_o,
  output logic [eva_pkg::pod_x_width_lp-1:0] pod_x_o,
  output logic [eva_pkg::pod_y_width_lp-1:0] pod_y_o
);
  import eva_pkg::*;

  // field lsbs inside the config word
  localparam int tgo_y_lsb_lp = x_sub_width_lp;
  localparam int pod_x_lsb_lp = tgo_y_lsb_lp + y_sub_width_lp;
  localparam int pod_y_lsb_lp = pod_x_lsb_lp + pod_x_width_lp;

  // new values show up the cycle after the write
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tgo_x_o <= '0;
      tgo_y_o <= '0;
      pod_x_o <= '0;
      pod_y_o <= '0;
    end else if (cfg_we_i) begin
      tgo_x_o <= cfg_data_i[x_sub_width_lp-1:0];
      tgo_y_o <= cfg_data_i[tgo_y_lsb_lp +: y_sub_width_lp];
      pod_x_o <= cfg_data_i[pod_x_lsb_lp +: pod_x_width_lp];
      pod_y_o <= cfg_data_i[pod_y_lsb_lp +: pod_y_width_lp];  // top of the word
    end
  end

endmodule

// ==== hdl/npa_req_stage.sv ====
// npa_req_stage: captures the translated npa on each request and pulses the response strobe
`timescale 1ns/1ps

module npa_req_stage (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                req_v_i,
  npa_if.sink                                 npa,
  output logic                                resp_v_o,
  output logic [eva_pkg::x_cord_width_lp-1:0] x_cord_o,
  output logic [eva_pkg::y_cord_width_lp-1:0] y_cord_o,
  output logic [eva_pkg::epa_width_lp-1:0]    epa_o,
  output logic                                invalid_o
);

  // one-cycle strobe, one response per request
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_v_o <= 1'b0;
    end else begin
      resp_v_o <= req_v_i;  // back-to-back requests keep it high
    end
  end

  // translation sampled with the request, held until the next one
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      x_cord_o  <= '0;
      y_cord_o  <= '0;
      epa_o     <= '0;
      invalid_o <= 1'b0;
    end else if (req_v_i) begin
      x_cord_o  <= npa.x_cord;
      y_cord_o  <= npa.y_cord;
      epa_o     <= npa.epa;
      invalid_o <= npa.invalid;
    end
  end

endmodule

// ==== hdl/eva_xlate_top.sv ====
// eva_xlate_top: config registers, eva to npa translator and registered response stage
`timescale 1ns/1ps

module eva_xlate_top (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                cfg_we_i,
  input  logic [eva_pkg::cfg_width_lp-1:0]    cfg_data_i,
  input  logic                                req_v_i,
  input  logic [eva_pkg::eva_width_lp-1:0]    eva_i,   // byte address
  output logic                                resp_v_o,
  output logic [eva_pkg::x_cord_width_lp-1:0] x_cord_o,
  output logic [eva_pkg::y_cord_width_lp-1:0] y_cord_o,
  output logic [eva_pkg::epa_width_lp-1:0]    epa_o,
  output logic                                invalid_o
);
  import eva_pkg::*;

  eva_u                      eva;    // raw bits seen through the union
  logic [x_sub_width_lp-1:0] tgo_x;
  logic [y_sub_width_lp-1:0] tgo_y;
  logic [pod_x_width_lp-1:0] pod_x;
  logic [pod_y_width_lp-1:0] pod_y;

  npa_if xlate_npa ();  // translator to output stage

  assign eva = eva_i;

  xlate_cfg cfg_u (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .cfg_we_i   (cfg_we_i),
    .cfg_data_i (cfg_data_i),
    .tgo_x_o    (tgo_x),
    .tgo_y_o    (tgo_y),
    .pod_x_o    (pod_x),
    .pod_y_o    (pod_y)
  );

  // combinational, same cycle as the request
  eva_to_npa xlate_u (
    .eva_i   (eva),
    .tgo_x_i (tgo_x),
    .tgo_y_i (tgo_y),
    .pod_x_i (pod_x),
    .pod_y_i (pod_y),
    .npa     (xlate_npa)
  );

  npa_req_stage req_stage_u (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_v_i   (req_v_i),
    .npa       (xlate_npa),
    .resp_v_o  (resp_v_o),
    .x_cord_o  (x_cord_o),
    .y_cord_o  (y_cord_o),
    .epa_o     (epa_o),
    .invalid_o (invalid_o)
  );

endmodule

// ==== dv/eva_xlate_checker.sv ====
// eva_xlate_checker: assertions on response timing, reset state and invalid zeroing, bound to the top
`timescale 1ns/1ps

module eva_xlate_checker (
  input logic                                clk_i,
  input logic                                rst_i,
  input logic                                req_v_i,
  input eva_pkg::eva_u                       eva_i,
  input logic                                resp_v_i,
  input logic [eva_pkg::x_cord_width_lp-1:0] x_cord_i,
  input logic [eva_pkg::y_cord_width_lp-1:0] y_cord_i,
  input logic [eva_pkg::epa_width_lp-1:0]    epa_i,
  input logic                                invalid_i
);
  import eva_pkg::*;

  logic unmapped;      // neither dram, global nor tile-group
  int   failures = 0;  // failed assertions so far

  assign unmapped = !eva_i[eva_width_lp-1] &&
                    (eva_i.global_v.remote != 2'b01) &&
                    (eva_i.tile_group_v.remote != 3'b001);

  // strobe one cycle after each request
  resp_after_req_a : assert property (@(posedge clk_i) disable iff (rst_i)
      req_v_i |=> resp_v_i)
    else begin
      $error("no response one cycle after a request");
      failures++;
    end

  // and never without one
  no_stray_resp_a : assert property (@(posedge clk_i) disable iff (rst_i)
      !req_v_i |=> !resp_v_i)
    else begin
      $error("response one cycle after an idle cycle");
      failures++;
    end

  // sync reset clears strobe and held npa
  reset_clear_a : assert property (@(posedge clk_i)
      rst_i |=> !resp_v_i && !invalid_i && (x_cord_i == '0) && (y_cord_i == '0) && (epa_i == '0))
    else begin
      $error("response stage not cleared by reset");
      failures++;
    end

  invalid_zero_a : assert property (@(posedge clk_i) disable iff (rst_i)
      invalid_i |-> (x_cord_i == '0) && (y_cord_i == '0) && (epa_i == '0))
    else begin
      $error("invalid response with nonzero coordinates or epa");
      failures++;
    end

  // top bits 000 must come back flagged
  unmapped_invalid_a : assert property (@(posedge clk_i) disable iff (rst_i)
      req_v_i && unmapped |=> invalid_i)
    else begin
      $error("unmapped eva not flagged invalid");
      failures++;
    end

endmodule

bind eva_xlate_top eva_xlate_checker checks_u (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .req_v_i   (req_v_i),
  .eva_i     (eva_i),
  .resp_v_i  (resp_v_o),
  .x_cord_i  (x_cord_o),
  .y_cord_i  (y_cord_o),
  .epa_i     (epa_o),
  .invalid_i (invalid_o)
);

// ==== dv/eva_xlate_tb.sv ====
// eva_xlate_tb: clock, reset, trace-driven stimulus, response monitor and compare tasks
`timescale 1ns/1ps

module eva_xlate_tb;
  import eva_pkg::*;

  localparam string trace_path_lp  = "dv/eva_xlate_trace.txt";
  localparam int    drain_limit_lp = 20;  // cycles allowed for the last responses

  logic                       clk;
  logic                       rst;
  logic                       cfg_we;
  logic [cfg_width_lp-1:0]    cfg_data;
  logic                       req_v;
  logic [eva_width_lp-1:0]    eva;
  logic                       resp_v;
  logic [x_cord_width_lp-1:0] x_cord;
  logic [y_cord_width_lp-1:0] y_cord;
  logic [epa_width_lp-1:0]    epa;
  logic                       invalid;

  // expected npa per outstanding request, oldest first
  logic [x_cord_width_lp-1:0] exp_x_q[$];
  logic [y_cord_width_lp-1:0] exp_y_q[$];
  logic [epa_width_lp-1:0]    exp_epa_q[$];
  logic                       exp_inv_q[$];

  int value_errors = 0;  // wrong npa fields
  int other_errors = 0;  // stray responses, timeouts, trace problems
  int req_count    = 0;
  int resp_count   = 0;

  eva_xlate_top eva_xlate_top_inst (
    .clk_i      (clk),
    .rst_i      (rst),
    .cfg_we_i   (cfg_we),
    .cfg_data_i (cfg_data),
    .req_v_i    (req_v),
    .eva_i      (eva),
    .resp_v_o   (resp_v),
    .x_cord_o   (x_cord),
    .y_cord_o   (y_cord),
    .epa_o      (epa),
    .invalid_o  (invalid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // y is zero extended to the x width
  task automatic compare_cord(input string name, input logic [x_cord_width_lp-1:0] got,
                              input logic [x_cord_width_lp-1:0] expected);
    if (got !== expected) begin
      value_errors++;
      $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, expected);
    end
  endtask

  task automatic compare_epa(input logic [epa_width_lp-1:0] got,
                             input logic [epa_width_lp-1:0] expected);
    if (got !== expected) begin
      value_errors++;
      $display("Error at %0t ns: epa is 0x%0h, expected 0x%0h", $time, got, expected);
    end
  endtask

  task automatic compare_invalid(input logic got, input logic expected);
    if (got !== expected) begin
      value_errors++;
      $display("Error at %0t ns: invalid is %b, expected %b", $time, got, expected);
    end
  endtask

  // one trace record per cycle, inputs change 1 ns after the edge
  task automatic drive_cycle(input logic we, input logic [cfg_width_lp-1:0] cfg,
                             input logic v, input logic [eva_width_lp-1:0] addr);
    @(posedge clk);
    #1;
    cfg_we   = we;
    cfg_data = cfg;
    req_v    = v;
    eva      = addr;
  endtask

  // outputs settle after the edge, look at them half a cycle later
  always @(negedge clk) begin
    if (!rst && resp_v) begin
      if (exp_x_q.size() == 0) begin
        other_errors++;
        $display("a response came at %0t ns with no request outstanding", $time);
      end else begin
        compare_cord("x_cord", x_cord, exp_x_q.pop_front());
        compare_cord("y_cord", {1'b0, y_cord}, {1'b0, exp_y_q.pop_front()});
        compare_epa(epa, exp_epa_q.pop_front());
        compare_invalid(invalid, exp_inv_q.pop_front());
        resp_count++;
      end
    end
  end

  initial begin
    int                         fd;
    int                         code;
    int                         wait_cycles;
    int                         assert_failures;
    bit                         done;
    logic [7:0]                 kind;          // record type letter
    logic [1023:0]              skipped_line;  // rest of a comment line
    logic [cfg_width_lp-1:0]    cfg_val;
    logic [eva_width_lp-1:0]    eva_val;
    logic [x_cord_width_lp-1:0] x_val;
    logic [y_cord_width_lp-1:0] y_val;
    logic [epa_width_lp-1:0]    epa_val;
    logic                       inv_val;

    rst      = 1'b1;
    cfg_we   = 1'b0;
    cfg_data = '0;
    req_v    = 1'b0;
    eva      = '0;
    done     = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;

    fd = $fopen(trace_path_lp, "r");
    if (fd == 0) begin
      other_errors++;
      $display("could not open the trace file %s", trace_path_lp);
      done = 1'b1;
    end
    while (!done) begin
      code = $fscanf(fd, "%s", kind);
      if (code != 1) begin
        done = 1'b1;  // end of trace
      end else if (kind == "#") begin
        code = $fgets(skipped_line, fd);
      end else if (kind == "i") begin
        drive_cycle(1'b0, '0, 1'b0, '0);
      end else if (kind == "c") begin
        code = $fscanf(fd, "%h", cfg_val);
        drive_cycle(1'b1, cfg_val, 1'b0, '0);
      end else if (kind == "r" || kind == "w") begin
        cfg_val = '0;
        if (kind == "w") begin
          code = $fscanf(fd, "%h", cfg_val);  // config write in the request cycle
        end
        code = $fscanf(fd, "%h %h %h %h %h", eva_val, x_val, y_val, epa_val, inv_val);
        if (code != 5) begin
          other_errors++;
          $display("trace request record %0d has missing fields", req_count + 1);
          done = 1'b1;
        end else begin
          drive_cycle(kind == "w", cfg_val, 1'b1, eva_val);
          exp_x_q.push_back(x_val);
          exp_y_q.push_back(y_val);
          exp_epa_q.push_back(epa_val);
          exp_inv_q.push_back(inv_val);
          req_count++;
        end
      end else begin
        other_errors++;
        $display("unknown record type in the trace file");
        done = 1'b1;
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    drive_cycle(1'b0, '0, 1'b0, '0);

    // outstanding responses, bounded wait
    wait_cycles = 0;
    while (exp_x_q.size() != 0 && wait_cycles < drain_limit_lp) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (exp_x_q.size() != 0) begin
      other_errors++;
      $display("timed out waiting for %0d responses", exp_x_q.size());
    end
    if (req_count == 0) begin
      other_errors++;
      $display("the trace file held no requests");
    end
    repeat (2) @(posedge clk);

    // failed assertions of the bound checker
    assert_failures = eva_xlate_top_inst.checks_u.failures;

    $display("requests %0d, responses %0d, value errors %0d, other errors %0d, assert errors %0d",
             req_count, resp_count, value_errors, other_errors, assert_failures);
    if (value_errors == 0 && other_errors == 0 && assert_failures == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== dv/eva_xlate_trace.txt ====
# c cfg: config write, cfg word {pod_y, pod_x, tgo_y, tgo_x} in hex; i: idle cycle
# r eva x y epa invalid: request and expected npa in hex; w cfg eva x y epa invalid: both in one cycle
# dram at pod (0,0), north row wraps to pod_y 7
r 80000000 00 3f 0000000 0
r 80000200 00 08 0000000 0
i
c 880
# dram at pod (1,2), blocks step through columns and rows
r 80000000 10 0f 0000000 0
r 80000024 11 0f 0000001 0
r 80000200 10 18 0000000 0
r 80000440 12 0f 0000008 0
r 800003fc 1f 18 0000007 0
r 80001234 11 18 0000025 0
r fffffffc 1f 18 0ffffff 0
# global, fields pass through
r 6aaa48d0 55 2a 0001234 0
r 7fffffff 7f 3f 0007fff 0
r 40020000 01 00 0000000 0
# tile-group origin (13,6) in pod (1,2)
c 8ed
r 21850080 12 11 0000020 0
r 200003fc 1d 16 00000ff 0
r 3efaeaf0 17 13 00002bc 0
# overflow boundary 0x100, 0x4ff, 0x500
r 20000400 10 0f 0400008 0
r 200013fc 1f 18 0400027 0
r 20001400 1d 16 0000100 0
# top bits 000
r 00000000 00 00 0000000 1
r 1ffffffc 00 00 0000000 1
r 12345678 00 00 0000000 1
# config change under back-to-back requests, pod (5,4) origin (1,7)
r 21850080 12 11 0000020 0
w 12f1 21850080 12 11 0000020 0
r 21850080 56 22 0000020 0
r 80000200 50 28 0000000 0
r 80000000 50 1f 0000000 0

// ==== filelist.f ====
hdl/eva_pkg.sv
hdl/npa_if.sv
hdl/dram_hash.sv
hdl/eva_to_npa.sv
hdl/xlate_cfg.sv
hdl/npa_req_stage.sv
hdl/eva_xlate_top.sv
dv/eva_xlate_checker.sv
dv/eva_xlate_tb.sv

// ==== Makefile ====
TOP := eva_xlate_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

obj_dir/V$(TOP): filelist.f hdl/*.sv dv/*.sv
	verilator --binary --assert --timescale 1ns/1ps -f filelist.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f filelist.f --top-module eva_xlate_top

clean:
	rm -rf obj_dir
